// File: include/packet_buffer_defines.svh
`ifndef PACKET_BUFFER_DEFINES_SVH
`define PACKET_BUFFER_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet buffer sizing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// bits of payload in one beat.
`define PB_DATA_WIDTH 8

// beats the queue can hold, kept a power of two.
`define PB_DEPTH 16

// log2 of the depth plus one, so a counter reaches the full depth.
`define PB_COUNT_WIDTH 5

`endif

// File: logic/beat_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "packet_buffer_defines.svh"

// circular buffer of beats with a registered read stage.
// the read stage counts toward occupancy, so the queue never holds
// more than PB_DEPTH beats in all.
module beat_queue (
    input  logic    aclk,
    input  logic    areset_n,
    stream_if.sink   wr,
    stream_if.source rd,
    output logic    full
);
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage and pointers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int addr_width = `PB_COUNT_WIDTH - 1; // pointer bits that index memory.
    localparam logic [`PB_COUNT_WIDTH-1:0] depth_count = `PB_COUNT_WIDTH'(`PB_DEPTH);

    packet_buffer_pkg::beat_t mem [`PB_DEPTH]; // beat storage.

    logic [`PB_COUNT_WIDTH-1:0] wr_ptr; // extra msb tells full from empty.
    logic [`PB_COUNT_WIDTH-1:0] rd_ptr;
    logic [`PB_COUNT_WIDTH-1:0] stored; // beats in memory.
    logic [`PB_COUNT_WIDTH-1:0] used;   // memory plus read stage.

    logic wr_fire; // beat accepted from the input.
    logic load;    // memory head moves into the read stage.

    assign stored  = wr_ptr - rd_ptr; // wraps correctly with the extra msb.
    assign used    = stored + `PB_COUNT_WIDTH'(rd.tvalid);
    assign full    = (used == depth_count);
    assign wr.tready = !full;
    assign wr_fire = wr.tvalid && wr.tready;

    // refill the read stage when it is empty or being drained.
    assign load = (stored != '0) && (!rd.tvalid || rd.tready);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge aclk) begin
        if (wr_fire) begin
            mem[wr_ptr[addr_width-1:0]] <= wr.beat; // payload only, no reset.
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            wr_ptr <= '0;
        end
        else if (wr_fire) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            rd_ptr <= '0;
        end
        else if (load) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // output valid.
    // set on a load, cleared once the held beat is taken with nothing behind it.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            rd.tvalid <= 1'b0;
        end
        else if (load) begin
            rd.tvalid <= 1'b1;
        end
        else if (rd.tready) begin
            rd.tvalid <= 1'b0;
        end
    end

    // output beat changes only on a load, so it stays put under back-pressure.
    always_ff @(posedge aclk) begin
        if (load) begin
            rd.beat <= mem[rd_ptr[addr_width-1:0]];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // an accepted write always finds a free slot in memory.
    a_no_write_when_full: assert property (
        @(posedge aclk) disable iff (!areset_n)
        wr_fire |-> (stored < depth_count)
    ) else $error("beat_queue write accepted while full");

    // a stalled output beat is neither withdrawn nor changed.
    a_rd_beat_stable: assert property (
        @(posedge aclk) disable iff (!areset_n)
        (rd.tvalid && !rd.tready) |=> (rd.tvalid && $stable(rd.beat))
    ) else $error("beat_queue output changed under back-pressure");

endmodule

`default_nettype wire

// File: logic/packet_buffer_pkg.sv
`default_nettype none

`include "packet_buffer_defines.svh"

package packet_buffer_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stream payload.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one beat of the byte stream, data in the upper bits.
    typedef struct packed {
        logic [`PB_DATA_WIDTH-1:0] data; // payload byte.
        logic                      last; // marks the final beat of a packet.
    } beat_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // packet gate states.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [0:0] {
        state_idle    = 1'b0, // queue output held back.
        state_release = 1'b1  // queue output follows the downstream ready.
    } gate_state_t;

endpackage

`default_nettype wire

// File: logic/packet_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "packet_buffer_defines.svh"

// store-and-forward packet buffer for a byte stream.
// a packet leaves only once it is complete in the queue, except when
// it is longer than the queue, then it streams through.
module packet_buffer_top (
    input  logic                      aclk,
    input  logic                      areset_n,

    // input stream.
    input  logic                      s_tvalid,
    output logic                      s_tready,
    input  logic [`PB_DATA_WIDTH-1:0] s_tdata,
    input  logic                      s_tlast,

    // output stream.
    output logic                      m_tvalid,
    input  logic                      m_tready,
    output logic [`PB_DATA_WIDTH-1:0] m_tdata,
    output logic                      m_tlast
);
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // streams.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    stream_if in_s (    // input port into the queue.
        .aclk (aclk)
    );

    stream_if q_out_s ( // queue read stage to the gate.
        .aclk (aclk)
    );

    stream_if out_s (   // gate output register to the output port.
        .aclk (aclk)
    );

    logic queue_full; // queue holds PB_DEPTH beats.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // port mapping.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // input side.
    assign in_s.tvalid = s_tvalid;
    assign in_s.beat   = packet_buffer_pkg::beat_t'{data: s_tdata, last: s_tlast};
    assign s_tready    = in_s.tready;

    // output side.
    assign m_tvalid     = out_s.tvalid;
    assign m_tdata      = out_s.beat.data;
    assign m_tlast      = out_s.beat.last;
    assign out_s.tready = m_tready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // holds the beats and drives s_tready.
    beat_queue u_queue (
        .aclk     (aclk),
        .areset_n (areset_n),
        .wr       (in_s.sink),
        .rd       (q_out_s.source),
        .full     (queue_full)
    );

    // watches the input for packet ends, decides when the queue may drain.
    packet_gate u_gate (
        .aclk     (aclk),
        .areset_n (areset_n),
        .mon      (in_s.monitor),
        .rx       (q_out_s.sink),
        .tx       (out_s.source),
        .full     (queue_full)
    );

endmodule

`default_nettype wire

// File: logic/packet_gate.sv
`timescale 1ns/1ps
`default_nettype none

`include "packet_buffer_defines.svh"

// holds the queue output back until the oldest packet is complete.
// a full queue with no complete packet is let through to avoid a deadlock.
module packet_gate (
    input  logic      aclk,
    input  logic      areset_n,
    stream_if.monitor mon,
    stream_if.sink    rx,
    stream_if.source  tx,
    input  logic      full
);
    localparam logic [`PB_COUNT_WIDTH-1:0] depth_count = `PB_COUNT_WIDTH'(`PB_DEPTH);

    packet_buffer_pkg::gate_state_t state;

    logic [`PB_COUNT_WIDTH-1:0] beat_count;        // beats held in the queue.
    logic [`PB_COUNT_WIDTH-1:0] packet_count;      // complete packets held in the queue.
    logic [`PB_COUNT_WIDTH-1:0] packet_count_next;

    logic beat_write;   // beat entered the queue.
    logic beat_read;    // beat left the queue toward the output.
    logic packet_write; // last beat entered.
    logic packet_read;  // last beat left.
    logic in_release;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transfer decode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign beat_write   = mon.tvalid && mon.tready;
    assign beat_read    = rx.tvalid && rx.tready;
    assign packet_write = beat_write && mon.beat.last;
    assign packet_read  = beat_read && rx.beat.last;
    assign in_release   = (state == packet_buffer_pkg::state_release);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // occupancy counters.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            beat_count <= '0;
        end
        else if (beat_write && !beat_read) begin
            beat_count <= beat_count + 1'b1;
        end
        else if (!beat_write && beat_read) begin
            beat_count <= beat_count - 1'b1;
        end
    end

    // next packet count, also needed by the fsm to spot the last one leaving.
    always_comb begin
        packet_count_next = packet_count;
        if (packet_write && !packet_read) begin
            packet_count_next = packet_count + 1'b1;
        end
        else if (!packet_write && packet_read) begin
            packet_count_next = packet_count - 1'b1;
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            packet_count <= '0;
        end
        else begin
            packet_count <= packet_count_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // release fsm.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            state <= packet_buffer_pkg::state_idle;
        end
        else begin
            case (state)
                packet_buffer_pkg::state_idle: begin
                    // a whole packet waits, or the queue is stuck full.
                    if ((packet_count != '0) || (full && !mon.tready)) begin
                        state <= packet_buffer_pkg::state_release;
                    end
                end
                packet_buffer_pkg::state_release: begin
                    if (packet_read && (packet_count_next == '0)) begin
                        state <= packet_buffer_pkg::state_idle; // nothing complete left.
                    end
                end
                default: begin
                    state <= packet_buffer_pkg::state_idle;
                end
            endcase
        end
    end

    // queue is read only in release, and only when the output register can load.
    assign rx.tready = in_release && tx.tready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            tx.tvalid <= 1'b0;
        end
        else if (tx.tready) begin
            tx.tvalid <= beat_read; // a beat taken now is shown next cycle.
        end
    end

    always_ff @(posedge aclk) begin
        if (tx.tready) begin
            tx.beat <= rx.beat;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a last beat can only leave after it was counted on the way in.
    a_packet_count_no_underflow: assert property (
        @(posedge aclk) disable iff (!areset_n)
        (packet_read && !packet_write) |-> (packet_count != '0)
    ) else $error("packet_gate packet count below zero");

    // the local beat count tracks the queue's own occupancy.
    a_full_matches_count: assert property (
        @(posedge aclk) disable iff (!areset_n)
        full == (beat_count == depth_count)
    ) else $error("packet_gate beat count disagrees with queue full flag");

endmodule

`default_nettype wire

// File: logic/stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// valid/ready stream carrying one beat per transfer.
// a transfer happens on a rising edge with tvalid and tready both high.
interface stream_if (
    input logic aclk
);
    logic                     tvalid; // beat is offered.
    logic                     tready; // sink accepts this cycle.
    packet_buffer_pkg::beat_t beat;   // data and last flag.

    // side that offers beats.
    // holds beat and tvalid until the transfer.
    modport source (
        input  aclk,
        output tvalid,
        output beat,
        input  tready
    );

    // side that accepts beats.
    modport sink (
        input  aclk,
        input  tvalid,
        input  beat,
        output tready
    );

    // passive view, used to count transfers from outside.
    modport monitor (
        input aclk,
        input tvalid,
        input tready,
        input beat
    );

endinterface

`default_nettype wire

// File: packet_buffer.f
+incdir+include
logic/packet_buffer_pkg.sv
logic/stream_if.sv
logic/beat_queue.sv
logic/packet_gate.sv
logic/packet_buffer_top.sv
testbench/packet_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the packet buffer testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f packet_buffer.f \
    --top-module packet_buffer_tb \
    -o packet_buffer_sim

output=$(./obj_dir/packet_buffer_sim)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "Verification passed"; then
    exit 0
else
    exit 1
fi

// File: testbench/packet_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "packet_buffer_defines.svh"

module packet_buffer_tb;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // dut signals and scoreboard state.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic                      aclk;
    logic                      areset_n;
    logic                      s_tvalid;
    logic                      s_tready;
    logic [`PB_DATA_WIDTH-1:0] s_tdata;
    logic                      s_tlast;
    logic                      m_tvalid;
    logic                      m_tready;
    logic [`PB_DATA_WIDTH-1:0] m_tdata;
    logic                      m_tlast;

    packet_buffer_pkg::beat_t sent_q[$]; // every beat accepted at the input, in order.
    logic sent_long[$];                  // beat belongs to a packet longer than the queue.

    int out_count      = 0; // beats seen at the output.
    int in_beat_count  = 0;
    int in_last_count  = 0; // packets fully accepted.
    int out_last_count = 0; // packets fully delivered.
    int mismatch_count = 0;
    int timeout_errors = 0;
    int other_errors   = 0;

    logic       current_long = 1'b0; // tag for beats of the packet being sent.
    logic [1:0] ready_mode   = 2'd2; // 0 random, 1 high, 2 held low.
    logic       fill_done    = 1'b0;

    packet_buffer_top dut (
        .aclk     (aclk),
        .areset_n (areset_n),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tdata  (s_tdata),
        .s_tlast  (s_tlast),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tdata  (m_tdata),
        .m_tlast  (m_tlast)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk; // 20 ns period.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model and compare tasks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // output order must equal input order.
    function automatic packet_buffer_pkg::beat_t expected_beat();
        return sent_q[out_count];
    endfunction

    // the packet now at the output has had its last beat accepted.
    function automatic logic packet_complete();
        return in_last_count > out_last_count;
    endfunction

    task automatic check_beat(input packet_buffer_pkg::beat_t got,
                              input packet_buffer_pkg::beat_t exp);
        if (got.data !== exp.data) begin
            mismatch_count++;
            $display("mismatch m_tdata beat %0d got %h expected %h", out_count, got.data, exp.data);
        end
        if (got.last !== exp.last) begin
            mismatch_count++;
            $display("mismatch m_tlast beat %0d got %h expected %h", out_count, got.last, exp.last);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // monitor, sampled mid-cycle where the handshake is stable.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge aclk) begin
        if (areset_n) begin
            // output first, so an input last in the same edge does not count.
            if (m_tvalid && m_tready) begin
                if (out_count >= sent_q.size()) begin
                    other_errors++;
                    $display("output beat %0d appeared with no input beat behind it", out_count);
                end
                else begin
                    if (!sent_long[out_count]) begin
                        check_flag("store_and_forward", packet_complete(), 1'b1);
                    end
                    check_beat(packet_buffer_pkg::beat_t'{data: m_tdata, last: m_tlast},
                               expected_beat());
                    // packet boundaries follow the sent stream.
                    if (expected_beat().last) begin
                        out_last_count++;
                    end
                end
                out_count++;
            end
            if (s_tvalid && s_tready) begin
                sent_q.push_back(packet_buffer_pkg::beat_t'{data: s_tdata, last: s_tlast});
                sent_long.push_back(current_long);
                in_beat_count++;
                if (s_tlast) in_last_count++;
            end
        end
    end

    // downstream ready pattern.
    always @(posedge aclk) begin
        #2;
        case (ready_mode)
            2'd0:    m_tready = (($urandom % 4) != 0); // mostly ready.
            2'd1:    m_tready = 1'b1;
            default: m_tready = 1'b0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus tasks, entered 2 ns after a rising edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic send_beat(input packet_buffer_pkg::beat_t b);
        int waited;
        waited   = 0;
        s_tvalid = 1'b1;
        s_tdata  = b.data;
        s_tlast  = b.last;
        @(negedge aclk);
        while (!s_tready && waited < 400) begin // held until the queue has room.
            waited++;
            @(negedge aclk);
        end
        if (!s_tready) begin
            timeout_errors++;
            $display("timeout: input beat was not accepted within 400 cycles");
        end
        @(posedge aclk);
        #2;
        s_tvalid = 1'b0;
    endtask

    task automatic send_packet(input int len, input logic long_pkt, input logic gaps);
        packet_buffer_pkg::beat_t b;
        int idle;
        current_long = long_pkt;
        for (int i = 0; i < len; i++) begin
            if (gaps && (($urandom % 4) == 0)) begin
                idle = 1 + int'($urandom % 3); // short bubble on the input.
                repeat (idle) @(posedge aclk);
                #2;
            end
            b.data = `PB_DATA_WIDTH'($urandom);
            b.last = (i == len - 1);
            send_beat(b);
        end
    endtask

    // waits until every accepted beat has left the buffer.
    task automatic wait_drained(input int limit);
        int waited;
        waited = 0;
        @(posedge aclk);
        while (out_count < sent_q.size() && waited < limit) begin
            waited++;
            @(posedge aclk);
        end
        if (out_count < sent_q.size()) begin
            timeout_errors++;
            $display("timeout: only %0d of %0d beats left the buffer", out_count, sent_q.size());
        end
        #2;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int len;
        int start_count;
        int waited;
        areset_n = 1'b0;
        s_tvalid = 1'b0;
        s_tdata  = '0;
        s_tlast  = 1'b0;
        m_tready = 1'b0;
        void'($urandom(32'hbc091f70));
        repeat (5) @(posedge aclk);
        #2;
        areset_n = 1'b1;

        // reset values.
        @(negedge aclk);
        check_flag("m_tvalid", m_tvalid, 1'b0);
        check_flag("s_tready", s_tready, 1'b1);
        @(posedge aclk);
        #2;

        // random packets, random gaps, random downstream ready.
        ready_mode = 2'd0;
        repeat (40) begin
            len = 1 + int'($urandom % (`PB_DEPTH - 1));
            send_packet(len, 1'b0, 1'b1);
        end
        wait_drained(2000);

        // back-pressure, the queue must fill and stop the input.
        ready_mode = 2'd2;
        @(posedge aclk);
        #2;
        start_count = in_beat_count;
        fork
            begin
                send_packet(12, 1'b0, 1'b0);
                send_packet(12, 1'b0, 1'b0);
                fill_done = 1'b1;
            end
        join_none
        waited = 0;
        @(negedge aclk);
        while (s_tready && waited < 100) begin
            waited++;
            @(negedge aclk);
        end
        if (s_tready) begin
            timeout_errors++;
            $display("timeout: s_tready never fell while the output was stalled");
        end
        check_flag("accepted_within_depth", (in_beat_count - start_count) <= `PB_DEPTH, 1'b1);
        repeat (10) @(negedge aclk);
        check_flag("s_tready", s_tready, 1'b0);
        check_flag("m_tvalid", m_tvalid, 1'b0); // output register never loaded.
        @(posedge aclk);
        #2;
        ready_mode = 2'd1;
        waited = 0;
        while (!fill_done && waited < 1000) begin
            waited++;
            @(posedge aclk);
        end
        if (!fill_done) begin
            timeout_errors++;
            $display("timeout: back-pressure packets were never fully sent");
        end
        #2;
        wait_drained(1000);

        // overflow packet streams through, then normal packets resume.
        ready_mode = 2'd0;
        send_packet(3 * `PB_DEPTH, 1'b1, 1'b1);
        send_packet(5, 1'b0, 1'b1);
        wait_drained(2000);

        $display("closing counts: %0d mismatches, %0d timeouts, %0d other errors",
                 mismatch_count, timeout_errors, other_errors);
        if (mismatch_count + timeout_errors + other_errors == 0) begin
            $display("Verification passed");
        end
        else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
